/* rtl/drive_pkg.sv */
// Shared types for the single-wheel position drive
// Angle and ratio widths, profiler states, the profiler to PWM command
// and the acceleration ramp table
package drive_pkg;

    localparam int ANGLE_COUNTS = 4096;  // Encoder counts per turn

    typedef logic [11:0] angle_t;  // Angle or distance, modulo one turn
    typedef logic [7:0]  ratio_t;  // PWM high time out of 255
    typedef logic [3:0]  step_t;   // Ramp table index

    typedef enum logic [2:0] {
        st_idle     = 3'd0,
        st_calc     = 3'd1,
        st_accel    = 3'd2,
        st_cruise   = 3'd3,
        st_decel    = 3'd4,
        st_shutdown = 3'd5
    } profile_state_t;

    // Command from profiler to PWM generator
    typedef struct packed {
        ratio_t ratio;      // Requested high time
        logic   direction;  // 0 clockwise, counts up
        logic   enable;     // Bridge enable
    } drive_cmd_t;

    // Acceleration curve, steep at first and flattening toward full speed
    function automatic ratio_t ramp_ratio(input step_t step);
        case (step)
            4'd0:    return 8'd11;
            4'd1:    return 8'd29;
            4'd2:    return 8'd48;
            4'd3:    return 8'd65;
            4'd4:    return 8'd82;
            4'd5:    return 8'd99;
            4'd6:    return 8'd113;
            4'd7:    return 8'd128;
            4'd8:    return 8'd141;
            4'd9:    return 8'd153;
            4'd10:   return 8'd164;
            4'd11:   return 8'd174;
            4'd12:   return 8'd185;
            4'd13:   return 8'd193;
            4'd14:   return 8'd200;
            default: return 8'd206;
        endcase
    endfunction

endpackage

/* rtl/quadrature_decoder.sv */
// Quadrature encoder decoder
// Brings A and B into the clock domain and turns each Gray-code step
// into a count on a wrapping 12-bit angle
`timescale 1ns/1ps

module quadrature_decoder (
    input  logic              clock,
    input  logic              reset_n,
    input  logic              enc_a,
    input  logic              enc_b,
    output drive_pkg::angle_t current_angle
);
    import drive_pkg::*;

    logic [1:0] a_sync;      // Two-flop synchronizer for A
    logic [1:0] b_sync;      // Two-flop synchronizer for B
    logic [1:0] ab_curr;
    logic [1:0] ab_prev;
    logic [3:0] transition;
    logic       count_en;
    angle_t     step_val;

    assign ab_curr    = {a_sync[1], b_sync[1]};
    assign transition = {ab_prev, ab_curr};

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            a_sync  <= 2'b00;
            b_sync  <= 2'b00;
            ab_prev <= 2'b00;
        end else begin
            a_sync  <= {a_sync[0], enc_a};
            b_sync  <= {b_sync[0], enc_b};
            ab_prev <= ab_curr;
        end
    end

    // Clockwise runs 00 01 11 10, counter-clockwise the reverse
    always_comb begin
        count_en = 1'b1;
        step_val = 12'd1;
        case (transition)
            4'b0001, 4'b0111, 4'b1110, 4'b1000: step_val = 12'd1;
            4'b0010, 4'b1011, 4'b1101, 4'b0100: step_val = 12'hfff;  // Minus one
            default: count_en = 1'b0;  // No change or illegal jump
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            current_angle <= '0;
        end else if (count_en) begin
            current_angle <= current_angle + step_val;  // Wraps at one turn
        end
    end

    // Both phases flipping between samples means edges were lost
    a_single_step: assert property (
        @(posedge clock) disable iff (!reset_n)
        (ab_prev ^ ab_curr) != 2'b11
    ) else $error("quadrature_decoder: A and B changed in the same sample");

endmodule

/* rtl/motion_profiler.sv */
// Motion profiler for the wheel drive
// Picks the shorter direction to the target, then ramps the PWM ratio
// up the table, cruises, and ramps down as the target comes near
`timescale 1ns/1ps

module motion_profiler #(
    parameter drive_pkg::angle_t TARGET_TOLERANCE = 12'd20,
    parameter int                PROFILE_DELAY    = 30
) (
    input  logic                  clock,
    input  logic                  reset_n,
    input  drive_pkg::angle_t     target_angle,
    input  drive_pkg::angle_t     current_angle,
    input  logic                  angle_update,
    input  logic                  abort_angle,
    input  logic                  pwm_done,
    output drive_pkg::drive_cmd_t cmd,
    output logic                  pwm_update,
    output logic                  angle_done
);
    import drive_pkg::*;

    localparam int DELAY_W = (PROFILE_DELAY > 1) ? $clog2(PROFILE_DELAY) : 1;
    localparam logic [DELAY_W-1:0] DELAY_LAST = DELAY_W'(PROFILE_DELAY - 1);
    localparam angle_t HALF_TURN = angle_t'(ANGLE_COUNTS / 2);
    localparam step_t  SMALL_TOP = 4'd8;
    localparam step_t  MED_TOP   = 4'd10;
    localparam step_t  BIG_TOP   = 4'd14;

    profile_state_t     state;
    profile_state_t     state_next;
    step_t              curr_step;
    step_t              step_next;
    step_t              top_step;     // Highest ramp step for this move
    logic [DELAY_W-1:0] delay_cnt;    // PWM periods spent on the current step
    angle_t             dist_cw;
    angle_t             dist_ccw;
    angle_t             dist_min;
    angle_t             remaining;
    angle_t             decel_limit;
    logic               dir_pick;
    logic               dir_q;
    logic               step_adv;
    logic               near_target;
    logic               arrived;
    logic               moving_next;
    ratio_t             ratio_q;
    ratio_t             ratio_next;

    // Distances both ways round, from the live encoder angle
    assign dist_cw   = target_angle - current_angle;
    assign dist_ccw  = current_angle - target_angle;
    assign dir_pick  = !(dist_cw < dist_ccw);      // Tie goes counter-clockwise
    assign dist_min  = dir_pick ? dist_ccw : dist_cw;
    assign remaining = dir_q ? dist_ccw : dist_cw;

    // Longer ramps need more room to slow down
    always_comb begin
        case (top_step)
            SMALL_TOP: decel_limit = 12'd16;
            MED_TOP:   decel_limit = 12'd32;
            default:   decel_limit = 12'd64;
        endcase
    end

    // A distance above half a turn means the wheel has gone past the target
    assign near_target = (remaining < decel_limit) || (remaining > HALF_TURN);
    assign arrived     = (remaining < TARGET_TOLERANCE) || (remaining > HALF_TURN);
    assign step_adv    = pwm_done && (delay_cnt == DELAY_LAST);

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (angle_update) state_next = st_calc;
            end
            st_calc: begin
                state_next = (dist_min <= TARGET_TOLERANCE) ? st_idle : st_accel;
            end
            st_accel: begin
                if (abort_angle || near_target) begin
                    state_next = st_decel;
                end else if (curr_step == top_step) begin
                    state_next = st_cruise;
                end
            end
            st_cruise: begin
                if (abort_angle || near_target) state_next = st_decel;
            end
            st_decel: begin
                if (arrived) state_next = st_shutdown;
            end
            st_shutdown: begin
                if (pwm_done) state_next = st_idle;  // Zero ratio has gone out
            end
            default: state_next = st_idle;
        endcase
    end

    always_comb begin
        step_next = curr_step;
        case (state)
            st_idle, st_calc: step_next = '0;
            st_accel: begin
                if (step_adv && (curr_step < top_step)) step_next = curr_step + 4'd1;
            end
            st_decel: begin
                if (step_adv && (curr_step != 4'd0)) step_next = curr_step - 4'd1;
            end
            default: step_next = curr_step;
        endcase
    end

    // First entry is loaded in calc so the generator has it when enable rises
    always_comb begin
        case (state_next)
            st_calc, st_accel, st_cruise, st_decel: ratio_next = ramp_ratio(step_next);
            default:                                ratio_next = '0;
        endcase
    end

    assign moving_next = state_next inside {st_accel, st_cruise, st_decel, st_shutdown};

    assign cmd.ratio     = ratio_q;
    assign cmd.direction = (state == st_calc) ? dir_pick : dir_q;
    assign cmd.enable    = moving_next;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state      <= st_idle;
            curr_step  <= '0;
            top_step   <= BIG_TOP;
            dir_q      <= 1'b0;
            delay_cnt  <= '0;
            ratio_q    <= '0;
            pwm_update <= 1'b0;
            angle_done <= 1'b0;
        end else begin
            state      <= state_next;
            curr_step  <= step_next;
            ratio_q    <= ratio_next;
            pwm_update <= (ratio_next != ratio_q);
            angle_done <= (state_next == st_idle) &&
                          ((state == st_shutdown) || (state == st_calc));

            if (state == st_calc) begin
                dir_q <= dir_pick;
                if (dist_min < 12'd10)      top_step <= SMALL_TOP;
                else if (dist_min < 12'd30) top_step <= MED_TOP;
                else                        top_step <= BIG_TOP;
            end

            // Count whole PWM periods on each ramp step
            if ((state == st_accel) || (state == st_decel)) begin
                if (step_adv) delay_cnt <= '0;
                else if (pwm_done) delay_cnt <= delay_cnt + 1'b1;
            end else begin
                delay_cnt <= '0;
            end
        end
    end

    a_step_bound: assert property (
        @(posedge clock) disable iff (!reset_n)
        curr_step <= top_step
    ) else $error("motion_profiler: ramp step above the top step of the move");

    // Done only in idle with the ratio at zero and the wheel at the target
    a_done_edge: assert property (
        @(posedge clock) disable iff (!reset_n)
        angle_done |-> (state == st_idle) && (ratio_q == '0) &&
                       ((dist_min <= TARGET_TOLERANCE) || (remaining > HALF_TURN))
    ) else $error("motion_profiler: angle_done away from the target or outside idle");

endmodule

/* rtl/pwm_generator.sv */
// PWM generator for the H-bridge
// Runs the period counter and applies a new ratio and direction only at
// a period boundary, flagging each completed period with pwm_done
`timescale 1ns/1ps

module pwm_generator #(
    parameter int PWM_PERIOD = 255  // Clocks per period, at most 256
) (
    input  logic                  clock,
    input  logic                  reset_n,
    input  drive_pkg::drive_cmd_t cmd,
    input  logic                  pwm_update,
    output logic                  pwm_out,
    output logic                  pwm_direction,
    output logic                  pwm_enable,
    output logic                  pwm_done
);
    import drive_pkg::*;

    localparam ratio_t LAST_COUNT = ratio_t'(PWM_PERIOD - 1);

    ratio_t period_cnt;
    ratio_t ratio_q;       // Ratio in force for the current period
    logic   pending;       // Update seen, waiting for the boundary
    logic   period_end;
    logic   period_start;

    assign period_end   = (period_cnt == LAST_COUNT);
    assign period_start = period_end || !pwm_enable;  // Next clock opens a period

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            period_cnt <= '0;
            pwm_enable <= 1'b0;
        end else begin
            pwm_enable <= cmd.enable;
            if (period_start) period_cnt <= '0;
            else period_cnt <= period_cnt + 8'd1;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ratio_q       <= '0;
            pwm_direction <= 1'b0;
            pending       <= 1'b0;
        end else if (period_start && (pending || pwm_update)) begin
            ratio_q       <= cmd.ratio;
            pwm_direction <= cmd.direction;
            pending       <= 1'b0;
        end else if (pwm_update) begin
            pending <= 1'b1;
        end
    end

    // High for ratio_q clocks from the start of each period
    assign pwm_out  = pwm_enable && (period_cnt < ratio_q);
    assign pwm_done = pwm_enable && period_end;

endmodule

/* rtl/wheel_drive_top.sv */
// Wheel position drive, top level
// Encoder decoder feeding the motion profiler, which commands the PWM stage
`timescale 1ns/1ps

module wheel_drive_top #(
    parameter drive_pkg::angle_t TARGET_TOLERANCE = 12'd20,
    parameter int                PROFILE_DELAY    = 30,
    parameter int                PWM_PERIOD       = 255
) (
    input  logic              clock,
    input  logic              reset_n,
    input  drive_pkg::angle_t target_angle,
    input  logic              angle_update,
    input  logic              abort_angle,
    input  logic              enc_a,
    input  logic              enc_b,
    output logic              pwm_out,
    output logic              pwm_direction,
    output logic              pwm_enable,
    output drive_pkg::angle_t current_angle,
    output logic              angle_done
);
    import drive_pkg::*;

    drive_cmd_t cmd;         // Ratio, direction and enable to the PWM stage
    logic       pwm_update;
    logic       pwm_done;

    quadrature_decoder u_decoder (
        .clock         (clock),
        .reset_n       (reset_n),
        .enc_a         (enc_a),
        .enc_b         (enc_b),
        .current_angle (current_angle)
    );

    motion_profiler #(
        .TARGET_TOLERANCE (TARGET_TOLERANCE),
        .PROFILE_DELAY    (PROFILE_DELAY)
    ) u_profiler (
        .clock         (clock),
        .reset_n       (reset_n),
        .target_angle  (target_angle),
        .current_angle (current_angle),
        .angle_update  (angle_update),
        .abort_angle   (abort_angle),
        .pwm_done      (pwm_done),
        .cmd           (cmd),
        .pwm_update    (pwm_update),
        .angle_done    (angle_done)
    );

    pwm_generator #(
        .PWM_PERIOD (PWM_PERIOD)
    ) u_pwm (
        .clock         (clock),
        .reset_n       (reset_n),
        .cmd           (cmd),
        .pwm_update    (pwm_update),
        .pwm_out       (pwm_out),
        .pwm_direction (pwm_direction),
        .pwm_enable    (pwm_enable),
        .pwm_done      (pwm_done)
    );

endmodule

/* bench/encoder_model.sv */
// Behavioral wheel motor with a quadrature encoder
// Steps one count every EDGE_CLOCKS clocks while the bridge is driven,
// and can be stepped directly for decoder checks
`timescale 1ns/1ps

module encoder_model #(
    parameter int PWM_PERIOD  = 32,
    parameter int EDGE_CLOCKS = 40
) (
    input  logic              clock,
    input  logic              reset_n,
    input  logic              pwm_out,
    input  logic              pwm_direction,
    input  logic              pwm_enable,
    output logic              enc_a,
    output logic              enc_b,
    output drive_pkg::angle_t position
);
    int   phase;              // Follows the generator's period counter
    int   edge_cnt;           // Clocks since the last driven edge
    int   gap_cnt;            // Spacing of forced edges
    int   force_req = 0;      // Edges asked for by force_edges
    int   force_done;
    logic force_ccw = 1'b0;
    logic seen_high;          // Bridge was on earlier in this period
    logic driven;

    assign enc_a  = position[1];
    assign enc_b  = position[1] ^ position[0];  // Gray code 00 01 11 10 counting up
    assign driven = pwm_enable && (seen_high || pwm_out);

    always @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            position   <= '0;
            phase      <= 0;
            edge_cnt   <= 0;
            gap_cnt    <= 0;
            force_done <= 0;
            seen_high  <= 1'b0;
        end else begin
            if (!pwm_enable || (phase == PWM_PERIOD - 1)) begin
                phase     <= 0;
                seen_high <= 1'b0;
            end else begin
                phase     <= phase + 1;
                seen_high <= seen_high || pwm_out;
            end

            if (driven) begin
                if (edge_cnt >= EDGE_CLOCKS - 1) begin
                    edge_cnt <= 0;
                    position <= pwm_direction ? position - 12'd1 : position + 12'd1;
                end else begin
                    edge_cnt <= edge_cnt + 1;
                end
            end else if (force_done != force_req) begin
                gap_cnt <= (gap_cnt == 3) ? 0 : gap_cnt + 1;
                if (gap_cnt == 3) begin  // Slow enough for the synchronizer
                    position   <= force_ccw ? position - 12'd1 : position + 12'd1;
                    force_done <= force_done + 1;
                end
            end
        end
    end

    // Moves the wheel by hand, returns once the last edge is out
    task automatic force_edges(input int count, input logic ccw);
        force_ccw = ccw;
        force_req = force_req + count;
        wait (force_done == force_req);
    endtask

endmodule

/* bench/tb_wheel_drive.sv */
// Testbench for the wheel position drive
// Decoder checks first, then a table of moves run against the motor model,
// checking direction, PWM high times, arrival band and abort behavior
`timescale 1ns/1ps

module tb_wheel_drive;
    import drive_pkg::*;

    localparam angle_t TARGET_TOLERANCE = 12'd20;
    localparam int     PROFILE_DELAY    = 2;
    localparam int     PWM_PERIOD       = 32;
    localparam int     EDGE_CLOCKS      = 40;
    localparam int     COAST        = (PWM_PERIOD + EDGE_CLOCKS - 1) / EDGE_CLOCKS;
    localparam int     DONE_LATENCY = 2;  // Clocks from angle_update low to angle_done
    localparam int     RANDOM_ROWS  = 3;
    localparam int     ROW_COUNT    = 4 + RANDOM_ROWS;
    localparam int     MOVE_CLOCKS  = (ANGLE_COUNTS / 2 + 64) * EDGE_CLOCKS
                                      + 32 * PROFILE_DELAY * PWM_PERIOD;
    localparam int     WATCHDOG_NS  = (ROW_COUNT * MOVE_CLOCKS + 4000) * 20;

    typedef struct packed {
        angle_t      target;
        logic        abort;
        logic [15:0] abort_delay;  // Clocks after angle_update
        logic        exp_dir;      // Shortest path, tie counter-clockwise
        logic        exp_move;
    } move_t;

    logic   clock;
    logic   reset_n;
    angle_t target_angle;
    logic   angle_update;
    logic   abort_angle;
    logic   enc_a;
    logic   enc_b;
    logic   pwm_out;
    logic   pwm_direction;
    logic   pwm_enable;
    angle_t current_angle;
    logic   angle_done;
    angle_t model_pos;
    angle_t forced_angle = '0;
    logic   exp_dir_now = 1'b0;
    logic   [15:0] lfsr = 16'd30728;

    // Period monitor state
    logic   enable_prev = 1'b0;
    logic   post_abort = 1'b0;
    logic   dropped = 1'b0;
    int     enable_rises = 0;
    int     phase = 0;
    int     high_cnt = 0;
    int     last_high = 0;
    int     abort_last = -1;

    wheel_drive_top #(
        .TARGET_TOLERANCE (TARGET_TOLERANCE),
        .PROFILE_DELAY    (PROFILE_DELAY),
        .PWM_PERIOD       (PWM_PERIOD)
    ) u_wheel_drive_top (
        .clock (clock), .reset_n (reset_n), .target_angle (target_angle),
        .angle_update (angle_update), .abort_angle (abort_angle),
        .enc_a (enc_a), .enc_b (enc_b), .pwm_out (pwm_out),
        .pwm_direction (pwm_direction), .pwm_enable (pwm_enable),
        .current_angle (current_angle), .angle_done (angle_done)
    );

    encoder_model #(.PWM_PERIOD (PWM_PERIOD), .EDGE_CLOCKS (EDGE_CLOCKS)) u_encoder (
        .clock (clock), .reset_n (reset_n), .pwm_out (pwm_out),
        .pwm_direction (pwm_direction), .pwm_enable (pwm_enable),
        .enc_a (enc_a), .enc_b (enc_b), .position (model_pos)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic check_equal(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("ERROR at %0t ns: %s, got %0d, expected %0d", $time, what, actual, expected);
            $display("=== FAIL ===");
            $fatal(1, "%s", what);
        end
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic random_angle(output angle_t value);
        value = '0;
        for (int i = 0; i < 12; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[10:0], lfsr[0]};
        end
    endtask

    function automatic logic shortest_dir(input angle_t from, input angle_t to);
        angle_t cw;
        angle_t ccw;
        cw  = to - from;
        ccw = from - to;
        return (cw < ccw) ? 1'b0 : 1'b1;
    endfunction

    function automatic int ring_distance(input angle_t a, input angle_t b);
        angle_t fwd;
        angle_t back;
        fwd  = a - b;
        back = b - a;
        return (fwd < back) ? int'(fwd) : int'(back);
    endfunction

    // Table entries above the period length show as a full period
    function automatic logic is_ramp_time(input int high);
        logic found;
        int   entry;
        found = (high == 0);
        for (int k = 0; k < 16; k++) begin
            entry = int'(ramp_ratio(step_t'(k)));
            if (high == ((entry < PWM_PERIOD) ? entry : PWM_PERIOD)) found = 1'b1;
        end
        return found;
    endfunction

    function automatic move_t make_row(input angle_t target, input logic abort,
                                       input logic [15:0] delay);
        return '{target, abort, delay, 1'b0, 1'b0};
    endfunction

    task automatic force_and_check(input int cw_edges, input int ccw_edges);
        u_encoder.force_edges(cw_edges, 1'b0);
        u_encoder.force_edges(ccw_edges, 1'b1);
        forced_angle = forced_angle + angle_t'(cw_edges) - angle_t'(ccw_edges);
        repeat (3) @(posedge clock);
        @(negedge clock);
        check_equal(int'(current_angle), int'(forced_angle), "decoded angle after forced edges");
    endtask

    // Measures pwm_out high clocks in each period of a move
    always @(negedge clock) begin
        if (pwm_enable) begin
            if (!enable_prev) begin
                enable_rises = enable_rises + 1;
                phase      = 0;
                high_cnt   = 0;
                last_high  = 0;
                dropped    = 1'b0;
                abort_last = -1;
            end
            if (phase == 0) post_abort = abort_angle;
            if (pwm_out) high_cnt = high_cnt + 1;
            check_equal(int'(pwm_direction), int'(exp_dir_now), "pwm_direction off shortest path");
            if (phase == PWM_PERIOD - 1) begin
                check_equal(int'(is_ramp_time(high_cnt)), 1, "period high time not a ramp entry");
                if (dropped) check_equal(int'(high_cnt > last_high), 0, "ramp rose after falling");
                if (post_abort && abort_last >= 0) begin
                    check_equal(int'(high_cnt > abort_last), 0, "high time rose after abort");
                end
                if (post_abort) abort_last = high_cnt;
                if (high_cnt < last_high) dropped = 1'b1;
                last_high = high_cnt;
                phase     = 0;
                high_cnt  = 0;
            end else begin
                phase = phase + 1;
            end
        end
        enable_prev = pwm_enable;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: no end of test after %0d ns, a move never finished", WATCHDOG_NS);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        move_t  rows[$];
        move_t  row;
        angle_t rnd;
        int     clocks;
        int     rises;

        target_angle = '0;
        angle_update = 1'b0;
        abort_angle  = 1'b0;
        reset_n      = 1'b0;
        repeat (16) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);
        check_equal(int'(pwm_enable), 0, "pwm_enable after reset");
        check_equal(int'(pwm_out), 0, "pwm_out after reset");
        check_equal(int'(angle_done), 0, "angle_done after reset");
        check_equal(int'(current_angle), 0, "current_angle after reset");

        force_and_check(37, 12);
        force_and_check(0, 121);  // Leaves the wheel at 4000

        rows.push_back(make_row(12'd100, 1'b0, 16'd0));  // Wraps through zero clockwise
        rows.push_back(make_row(12'd90, 1'b0, 16'd0));   // Inside tolerance
        rows.push_back(make_row(12'd700, 1'b1, 16'd100)); // Abort while the ramp still climbs
        rows.push_back(make_row(12'd300, 1'b0, 16'd0));
        for (int i = 0; i < RANDOM_ROWS; i++) begin
            random_angle(rnd);
            rows.push_back(make_row(rnd, 1'b0, 16'd0));
        end

        foreach (rows[i]) begin
            row          = rows[i];
            row.exp_dir  = shortest_dir(model_pos, row.target);
            row.exp_move = ring_distance(model_pos, row.target) > int'(TARGET_TOLERANCE);
            exp_dir_now  = row.exp_dir;
            rises        = enable_rises;
            @(posedge clock);
            target_angle <= row.target;
            angle_update <= 1'b1;
            @(posedge clock);
            angle_update <= 1'b0;
            clocks = 0;
            do begin
                @(posedge clock);
                clocks = clocks + 1;
                if (row.abort && (clocks == int'(row.abort_delay))) abort_angle <= 1'b1;
            end while (!angle_done);
            abort_angle <= 1'b0;
            if (!row.exp_move) check_equal(clocks, DONE_LATENCY, "angle_done latency, short move");
            repeat (8) @(posedge clock);  // Last edge through the decoder
            @(negedge clock);
            check_equal(enable_rises - rises, int'(row.exp_move), "pwm_enable rises in move");
            check_equal(int'(current_angle), int'(model_pos), "decoded angle against motor");
            check_equal(int'(ring_distance(current_angle, row.target) <= int'(TARGET_TOLERANCE) + COAST),
                        1, "final angle outside arrival band");
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

/* project.f */
rtl/drive_pkg.sv
rtl/quadrature_decoder.sv
rtl/motion_profiler.sv
rtl/pwm_generator.sv
rtl/wheel_drive_top.sv
bench/encoder_model.sv
bench/tb_wheel_drive.sv

/* Makefile */
# Verilator build and run for the wheel position drive

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP       := tb_wheel_drive
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
